// File: ntm_trainer_params.svh
// Build-time sizes. NTM_L and NTM_X must be powers of two and at least 2, and T is at least 1
`ifndef NTM_TRAINER_PARAMS_SVH
`define NTM_TRAINER_PARAMS_SVH

////////////////////////////////////////
// Fixed-point format
////////////////////////////////////////

`define NTM_DATA_W 16 // Word width, signed
`define NTM_FRAC_W 8  // Fraction bits, Q8.8

////////////////////////////////////////
// Network dimensions
////////////////////////////////////////

// Layer neurons
`define NTM_L 4

// Input vector length
`define NTM_X 4

// Width of the runtime step count T
`define NTM_STEP_W 8

`endif

// File: ntm_trainer_pkg.sv
// Payload types and the Q8.8 multiply. Products truncate toward minus infinity and all sums wrap
`include "ntm_trainer_params.svh"

package ntm_trainer_pkg;

  ////////////////////////////////////////
  // Words and indices
  ////////////////////////////////////////

  typedef logic signed [`NTM_DATA_W-1:0] data_t;   // One fixed-point word
  typedef logic [$clog2(`NTM_L)-1:0]     lidx_t;   // Neuron index
  typedef logic [$clog2(`NTM_X)-1:0]     xidx_t;   // Input index

  // 1.0 in fixed point
  localparam data_t FX_ONE = data_t'(1 << `NTM_FRAC_W);

  ////////////////////////////////////////
  // Stream beats
  ////////////////////////////////////////

  // One neuron for one step
  typedef struct packed {
    data_t ds;  // Cell state gradient
    data_t a;   // Candidate activation
    data_t gi;  // Input gate value
  } gate_beat_t;

  typedef struct packed {
    data_t di;  // Gate delta
    lidx_t l;   // Owning neuron
  } delta_t;

  typedef struct packed {
    data_t data;
    logic  is_bias; // High for db words
    lidx_t row;
    xidx_t col;     // Zero for db words
    logic  last;    // Final word of the run
  } out_beat_t;

  // Full signed product, arithmetic shift by the fraction, low word kept
  function automatic data_t fx_mul(data_t a, data_t b);
    logic signed [2*`NTM_DATA_W-1:0] full;
    full = a * b;
    return data_t'(full >>> `NTM_FRAC_W);
  endfunction

endpackage

// File: ntm_ctrl_pkg.sv
// Controller encodings. State values are not part of any external interface
package ntm_ctrl_pkg;

  ////////////////////////////////////////
  // Run state machine
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    IDLE,     // Waiting for a start transfer
    LOAD_X,   // Filling the x buffer for one step
    GATE,     // Taking one gate beat per neuron
    FLUSH,    // Letting the delta pipeline drain
    DRAIN_W,  // Streaming dW row-major
    DRAIN_B   // Streaming db
  } trainer_state_e;

  ////////////////////////////////////////
  // Readout selection
  ////////////////////////////////////////

  // Picks the register file behind rd_data
  typedef enum logic {
    KIND_WEIGHT,
    KIND_BIAS
  } out_kind_e;

endpackage

// File: ntm_input_gate_delta.sv
// Fixed 3-cycle latency with no stall. The consumer must take delta on every delta_valid cycle
`timescale 1ns/10ps
`include "ntm_trainer_params.svh"

module ntm_input_gate_delta (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        in_valid,
  input  ntm_trainer_pkg::gate_beat_t in_beat,
  input  ntm_trainer_pkg::lidx_t      in_l,
  output logic                        delta_valid,
  output ntm_trainer_pkg::delta_t     delta,
  output logic                        busy
);

  // Partial product with what is still needed downstream
  typedef struct packed {
    ntm_trainer_pkg::data_t prod;
    ntm_trainer_pkg::data_t gi;
    ntm_trainer_pkg::data_t comp; // 1 - i
    ntm_trainer_pkg::lidx_t l;
  } stage_t;

  logic   v1, v2, v3; // Stage valids
  stage_t s1, s2;
  ntm_trainer_pkg::delta_t s3;

  ////////////////////////////////////////
  // Valid chain
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
      v3 <= 1'b0;
    end else begin
      v1 <= in_valid;
      v2 <= v1;
      v3 <= v2;
    end
  end

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    // Stage 1 forms ds o a and the complement of i
    if (in_valid) begin
      s1.prod <= ntm_trainer_pkg::fx_mul(in_beat.ds, in_beat.a);
      s1.gi   <= in_beat.gi;
      s1.comp <= ntm_trainer_pkg::FX_ONE - in_beat.gi; // Wraps like every sum
      s1.l    <= in_l;
    end
    // Stage 2 folds in i
    if (v1) begin
      s2      <= s1;
      s2.prod <= ntm_trainer_pkg::fx_mul(s1.prod, s1.gi);
    end
    // Stage 3 folds in 1 - i
    if (v2) begin
      s3.di <= ntm_trainer_pkg::fx_mul(s2.prod, s2.comp);
      s3.l  <= s2.l;
    end
  end

  assign delta_valid = v3;
  assign delta       = s3;
  assign busy        = v1 | v2 | v3; // Anything still in flight

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // No stage carries X while valid
  a_stage_known : assert property (@(posedge CLK) disable iff (RST)
    !(v1 && $isunknown(s1)) && !(v2 && $isunknown(s2)) && !(v3 && $isunknown(s3)));

endmodule

// File: ntm_gradient_accumulator.sv
// dW and db wrap at word width. The x buffer must hold while deltas of its step are in flight
`timescale 1ns/10ps
`include "ntm_trainer_params.svh"

module ntm_gradient_accumulator (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     clear,
  input  logic                     x_we,
  input  ntm_trainer_pkg::xidx_t   x_idx,
  input  ntm_trainer_pkg::data_t   x_data,
  input  logic                     delta_valid,
  input  ntm_trainer_pkg::delta_t  delta,
  input  ntm_ctrl_pkg::out_kind_e  rd_kind,
  input  ntm_trainer_pkg::lidx_t   rd_l,
  input  ntm_trainer_pkg::xidx_t   rd_x,
  output ntm_trainer_pkg::data_t   rd_data
);

  ntm_trainer_pkg::data_t x_buf [`NTM_X];          // Current step inputs
  ntm_trainer_pkg::data_t dw    [`NTM_L][`NTM_X];  // Weight gradient
  ntm_trainer_pkg::data_t db    [`NTM_L];          // Bias gradient

  ////////////////////////////////////////
  // x buffer
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (x_we) begin
      x_buf[x_idx] <= x_data;
    end
  end

  ////////////////////////////////////////
  // Gradient register files
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int l = 0; l < `NTM_L; l++) begin
        db[l] <= '0;
        for (int x = 0; x < `NTM_X; x++) begin
          dw[l][x] <= '0;
        end
      end
    end else if (clear) begin // New run
      for (int l = 0; l < `NTM_L; l++) begin
        db[l] <= '0;
        for (int x = 0; x < `NTM_X; x++) begin
          dw[l][x] <= '0;
        end
      end
    end else if (delta_valid) begin
      // Whole row l in one edge
      for (int x = 0; x < `NTM_X; x++) begin
        dw[delta.l][x] <= dw[delta.l][x] + ntm_trainer_pkg::fx_mul(delta.di, x_buf[x]);
      end
      db[delta.l] <= db[delta.l] + delta.di; // Plain sum of di
    end
  end

  ////////////////////////////////////////
  // Readout
  ////////////////////////////////////////

  // Combinational read of the address the controller holds
  always_comb begin
    if (rd_kind == ntm_ctrl_pkg::KIND_BIAS) begin
      rd_data = db[rd_l];
    end else begin
      rd_data = dw[rd_l][rd_x];
    end
  end

  // Start only comes while the pipeline is empty
  a_clear_vs_delta : assert property (@(posedge CLK) disable iff (RST)
    !(clear && delta_valid));

endmodule

// File: ntm_trainer_controller.sv
// steps must be at least 1. Each step waits for the delta pipeline to empty before new x is taken
`timescale 1ns/10ps
`include "ntm_trainer_params.svh"

module ntm_trainer_controller (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       start_valid,
  output logic                       start_ready,
  input  logic [`NTM_STEP_W-1:0]     steps,
  input  logic                       x_valid,
  output logic                       x_ready,
  input  logic                       gate_valid,
  output logic                       gate_ready,
  output logic                       out_valid,
  input  logic                       out_ready,
  output logic                       gate_fire,
  output ntm_trainer_pkg::lidx_t     gate_l,
  output logic                       x_we,
  output ntm_trainer_pkg::xidx_t     x_idx,
  output logic                       acc_clear,
  input  logic                       pipe_busy,
  output ntm_ctrl_pkg::out_kind_e    rd_kind,
  output ntm_trainer_pkg::lidx_t     rd_l,
  output ntm_trainer_pkg::xidx_t     rd_x,
  input  ntm_trainer_pkg::data_t     rd_data,
  output ntm_trainer_pkg::out_beat_t out
);

  ntm_ctrl_pkg::trainer_state_e state;

  logic [`NTM_STEP_W-1:0] steps_q;  // T of the current run
  logic [`NTM_STEP_W-1:0] step_cnt; // 1-based step number
  ntm_trainer_pkg::lidx_t cnt_l;
  ntm_trainer_pkg::xidx_t cnt_x;
  logic start_fire, out_fire;
  logic last_l, last_x;

  ////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////

  assign start_ready = (state == ntm_ctrl_pkg::IDLE);
  assign x_ready     = (state == ntm_ctrl_pkg::LOAD_X);
  assign gate_ready  = (state == ntm_ctrl_pkg::GATE);
  assign out_valid   = (state == ntm_ctrl_pkg::DRAIN_W) || (state == ntm_ctrl_pkg::DRAIN_B);

  assign start_fire = start_valid & start_ready;
  assign out_fire   = out_valid & out_ready;
  assign x_we       = x_valid & x_ready;
  assign gate_fire  = gate_valid & gate_ready; // One-cycle pulse into the delta unit
  assign acc_clear  = start_fire;

  assign last_l = (cnt_l == ntm_trainer_pkg::lidx_t'(`NTM_L - 1));
  assign last_x = (cnt_x == ntm_trainer_pkg::xidx_t'(`NTM_X - 1));

  // Same counters address loading, gating and readout
  assign x_idx  = cnt_x;
  assign gate_l = cnt_l;
  assign rd_l   = cnt_l;
  assign rd_x   = cnt_x;
  assign rd_kind = (state == ntm_ctrl_pkg::DRAIN_B) ? ntm_ctrl_pkg::KIND_BIAS
                                                    : ntm_ctrl_pkg::KIND_WEIGHT;

  ////////////////////////////////////////
  // Run FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= ntm_ctrl_pkg::IDLE;
      steps_q  <= '0;
      step_cnt <= '0;
      cnt_l    <= '0;
      cnt_x    <= '0;
    end else begin
      case (state)
        ntm_ctrl_pkg::IDLE: begin
          if (start_fire) begin
            steps_q  <= steps;
            step_cnt <= `NTM_STEP_W'(1);
            cnt_l    <= '0;
            cnt_x    <= '0;
            state    <= ntm_ctrl_pkg::LOAD_X;
          end
        end
        ntm_ctrl_pkg::LOAD_X: begin
          if (x_we) begin
            if (last_x) begin
              cnt_x <= '0;
              state <= ntm_ctrl_pkg::GATE;
            end else begin
              cnt_x <= cnt_x + 1'b1;
            end
          end
        end
        ntm_ctrl_pkg::GATE: begin
          if (gate_fire) begin
            if (last_l) begin
              cnt_l <= '0;
              state <= ntm_ctrl_pkg::FLUSH;
            end else begin
              cnt_l <= cnt_l + 1'b1;
            end
          end
        end
        ntm_ctrl_pkg::FLUSH: begin
          // x buffer is reused, so every step drains first
          if (!pipe_busy) begin
            if (step_cnt == steps_q) begin
              state <= ntm_ctrl_pkg::DRAIN_W;
            end else begin
              step_cnt <= step_cnt + 1'b1;
              state    <= ntm_ctrl_pkg::LOAD_X;
            end
          end
        end
        ntm_ctrl_pkg::DRAIN_W: begin
          if (out_fire) begin // Row-major walk
            if (last_x) begin
              cnt_x <= '0;
              if (last_l) begin
                cnt_l <= '0;
                state <= ntm_ctrl_pkg::DRAIN_B;
              end else begin
                cnt_l <= cnt_l + 1'b1;
              end
            end else begin
              cnt_x <= cnt_x + 1'b1;
            end
          end
        end
        ntm_ctrl_pkg::DRAIN_B: begin
          if (out_fire) begin
            if (last_l) begin
              cnt_l <= '0;
              state <= ntm_ctrl_pkg::IDLE; // Run done
            end else begin
              cnt_l <= cnt_l + 1'b1;
            end
          end
        end
        default: state <= ntm_ctrl_pkg::IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Output beat
  ////////////////////////////////////////

  always_comb begin
    out.data    = rd_data;
    out.is_bias = (rd_kind == ntm_ctrl_pkg::KIND_BIAS);
    out.row     = cnt_l;
    out.col     = cnt_x; // Zero through the db words
    out.last    = (state == ntm_ctrl_pkg::DRAIN_B) && last_l;
  end

  // Stalled beat stays put until taken
  a_out_hold : assert property (@(posedge CLK) disable iff (RST)
    (out_valid && !out_ready) |=> (out_valid && $stable(out)));

endmodule

// File: ntm_input_trainer.sv
// Input gate trainer for dW and db. L and X are fixed at build time and only T is set per run
`timescale 1ns/10ps
`include "ntm_trainer_params.svh"

module ntm_input_trainer (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       start_valid,
  output logic                       start_ready,
  input  logic [`NTM_STEP_W-1:0]     steps,
  input  logic                       x_valid,
  output logic                       x_ready,
  input  ntm_trainer_pkg::data_t     x_data,
  input  logic                       gate_valid,
  output logic                       gate_ready,
  input  ntm_trainer_pkg::gate_beat_t gate,
  output logic                       out_valid,
  input  logic                       out_ready,
  output ntm_trainer_pkg::out_beat_t out
);

  ////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////

  logic                     gate_fire;
  ntm_trainer_pkg::lidx_t   gate_l;
  logic                     x_we;
  ntm_trainer_pkg::xidx_t   x_idx;
  logic                     acc_clear;
  logic                     pipe_busy;
  logic                     delta_valid;
  ntm_trainer_pkg::delta_t  delta;
  ntm_ctrl_pkg::out_kind_e  rd_kind;
  ntm_trainer_pkg::lidx_t   rd_l;
  ntm_trainer_pkg::xidx_t   rd_x;
  ntm_trainer_pkg::data_t   rd_data;

  // Sequencing and all stream handshakes
  ntm_trainer_controller i_ntm_trainer_controller (
    .CLK         (CLK),
    .RST         (RST),
    .start_valid (start_valid),
    .start_ready (start_ready),
    .steps       (steps),
    .x_valid     (x_valid),
    .x_ready     (x_ready),
    .gate_valid  (gate_valid),
    .gate_ready  (gate_ready),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .gate_fire   (gate_fire),
    .gate_l      (gate_l),
    .x_we        (x_we),
    .x_idx       (x_idx),
    .acc_clear   (acc_clear),
    .pipe_busy   (pipe_busy),
    .rd_kind     (rd_kind),
    .rd_l        (rd_l),
    .rd_x        (rd_x),
    .rd_data     (rd_data),
    .out         (out)
  );

  // di = ds o a o i o (1 - i)
  ntm_input_gate_delta i_ntm_input_gate_delta (
    .CLK         (CLK),
    .RST         (RST),
    .in_valid    (gate_fire),
    .in_beat     (gate),      // Payload goes straight in on the accept cycle
    .in_l        (gate_l),
    .delta_valid (delta_valid),
    .delta       (delta),
    .busy        (pipe_busy)
  );

  // dW and db register files
  ntm_gradient_accumulator i_ntm_gradient_accumulator (
    .CLK         (CLK),
    .RST         (RST),
    .clear       (acc_clear),
    .x_we        (x_we),
    .x_idx       (x_idx),
    .x_data      (x_data),
    .delta_valid (delta_valid),
    .delta       (delta),
    .rd_kind     (rd_kind),
    .rd_l        (rd_l),
    .rd_x        (rd_x),
    .rd_data     (rd_data)
  );

endmodule

// File: tb_ntm_input_trainer.sv
// Table-driven testbench with its own Q8.8 model. The hand-checked directed word assumes NTM_FRAC_W of 8
`timescale 1ns/10ps
`include "ntm_trainer_params.svh"

module tb_ntm_input_trainer;

  localparam int N_ROWS = 5;
  localparam int N_OUT  = `NTM_L * `NTM_X + `NTM_L; // dW words then db words
  localparam ntm_trainer_pkg::data_t Q_ONE = `NTM_DATA_W'(1) << `NTM_FRAC_W;

  // One run of the DUT
  typedef struct packed {
    int steps;    // T
    int in_pct;   // Chance per cycle of x_valid and gate_valid
    int out_pct;  // Chance per cycle of out_ready
    bit directed; // Fixed values instead of random words
  } test_row_t;

  logic                        CLK;
  logic                        RST;
  logic                        start_valid;
  logic                        start_ready;
  logic [`NTM_STEP_W-1:0]      steps;
  logic                        x_valid;
  logic                        x_ready;
  ntm_trainer_pkg::data_t      x_data;
  logic                        gate_valid;
  logic                        gate_ready;
  ntm_trainer_pkg::gate_beat_t gate;
  logic                        out_valid;
  logic                        out_ready;
  ntm_trainer_pkg::out_beat_t  out;

  test_row_t                   rows [N_ROWS];
  ntm_trainer_pkg::data_t      xq [$];    // x stream of the current run
  ntm_trainer_pkg::gate_beat_t gq [$];    // Gate stream of the current run
  ntm_trainer_pkg::out_beat_t  exp_q [$]; // Expected output order
  int cycles = 0;
  int cycle_limit;

  ntm_input_trainer i_ntm_input_trainer (
    .CLK         (CLK),
    .RST         (RST),
    .start_valid (start_valid),
    .start_ready (start_ready),
    .steps       (steps),
    .x_valid     (x_valid),
    .x_ready     (x_ready),
    .x_data      (x_data),
    .gate_valid  (gate_valid),
    .gate_ready  (gate_ready),
    .gate        (gate),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out         (out)
  );

  initial CLK = 1'b0;
  always #5 CLK = ~CLK; // 10 ns

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Sign-extend both, keep the word that sits above the fraction bits
  function automatic ntm_trainer_pkg::data_t q_mul(ntm_trainer_pkg::data_t p,
                                                   ntm_trainer_pkg::data_t q);
    logic signed [2*`NTM_DATA_W-1:0] pe;
    logic signed [2*`NTM_DATA_W-1:0] qe;
    logic signed [2*`NTM_DATA_W-1:0] full;
    pe   = {{`NTM_DATA_W{p[`NTM_DATA_W-1]}}, p};
    qe   = {{`NTM_DATA_W{q[`NTM_DATA_W-1]}}, q};
    full = pe * qe;
    return full[`NTM_FRAC_W +: `NTM_DATA_W];
  endfunction

  // di = ds o a o i o (1 - i), left to right
  function automatic ntm_trainer_pkg::data_t gate_delta(ntm_trainer_pkg::gate_beat_t g);
    return q_mul(q_mul(q_mul(g.ds, g.a), g.gi), Q_ONE - g.gi);
  endfunction

  function automatic bit chance(int pct);
    return int'($urandom_range(99)) < pct;
  endfunction

  function automatic int cycle_budget();
    int sum;
    sum = 0;
    for (int r = 0; r < N_ROWS; r++) begin
      sum += rows[r].steps * (`NTM_X + `NTM_L) + `NTM_L * `NTM_X + `NTM_L;
    end
    return 4 * sum + 100;
  endfunction

  task automatic stop_with_failure();
    $display("Regression failed");
    $fatal(1);
  endtask

  // Streams and expected beats for one row
  task automatic build_row(input int r);
    ntm_trainer_pkg::data_t      dw_m [`NTM_L][`NTM_X];
    ntm_trainer_pkg::data_t      db_m [`NTM_L];
    ntm_trainer_pkg::data_t      xs [`NTM_X];
    ntm_trainer_pkg::data_t      di;
    ntm_trainer_pkg::gate_beat_t g;
    ntm_trainer_pkg::out_beat_t  b;
    xq.delete();
    gq.delete();
    exp_q.delete();
    for (int l = 0; l < `NTM_L; l++) begin
      db_m[l] = '0;
      for (int x = 0; x < `NTM_X; x++) begin
        dw_m[l][x] = '0;
      end
    end
    for (int t = 0; t < rows[r].steps; t++) begin
      for (int x = 0; x < `NTM_X; x++) begin // 1.0, 1.25, 1.5 ... when directed
        xs[x] = rows[r].directed ? Q_ONE + ntm_trainer_pkg::data_t'(x * 'h40)
                                 : ntm_trainer_pkg::data_t'($urandom);
        xq.push_back(xs[x]);
      end
      for (int l = 0; l < `NTM_L; l++) begin
        if (rows[r].directed) begin
          g.ds = ntm_trainer_pkg::data_t'((l + 1) << `NTM_FRAC_W);
          g.a  = 16'sh0080; // 0.5
          g.gi = 16'sh0040; // 0.25
        end else begin
          g.ds = ntm_trainer_pkg::data_t'($urandom);
          g.a  = ntm_trainer_pkg::data_t'($urandom);
          g.gi = ntm_trainer_pkg::data_t'($urandom);
        end
        gq.push_back(g);
        di = gate_delta(g);
        db_m[l] = db_m[l] + di; // Wraps at 16 bits
        for (int x = 0; x < `NTM_X; x++) begin
          dw_m[l][x] = dw_m[l][x] + q_mul(di, xs[x]);
        end
      end
    end
    // Row-major dW, then db with last on the final word
    for (int l = 0; l < `NTM_L; l++) begin
      for (int x = 0; x < `NTM_X; x++) begin
        b = '{data: dw_m[l][x], is_bias: 1'b0, row: ntm_trainer_pkg::lidx_t'(l),
              col: ntm_trainer_pkg::xidx_t'(x), last: 1'b0};
        exp_q.push_back(b);
      end
    end
    for (int l = 0; l < `NTM_L; l++) begin
      b = '{data: db_m[l], is_bias: 1'b1, row: ntm_trainer_pkg::lidx_t'(l),
            col: '0, last: (l == `NTM_L - 1)};
      exp_q.push_back(b);
    end
    // 1.0 * 0.5 * 0.25 * 0.75 worked by hand is 0x0018
    if (rows[r].directed) begin
      assert (exp_q[0].data == 16'sh0018 && exp_q[`NTM_L*`NTM_X].data == 16'sh0018) else begin
        $display("MISMATCH model dW[0][0] %h db[0] %h, hand value 0018",
                 exp_q[0].data, exp_q[`NTM_L*`NTM_X].data);
        stop_with_failure();
      end
    end
  endtask

  task automatic check_beat(input int r, input int idx);
    assert (out.data == exp_q[idx].data) else begin
      $display("MISMATCH out.data row %0d beat %0d: got %h expected %h",
               r, idx, out.data, exp_q[idx].data);
      stop_with_failure();
    end
    assert (out == exp_q[idx]) else begin // Tags, order and last
      $display("MISMATCH out row %0d beat %0d: got %h expected %h", r, idx, out, exp_q[idx]);
      stop_with_failure();
    end
  endtask

  ////////////////////////////////////////
  // One run, cycle by cycle
  ////////////////////////////////////////

  task automatic run_row(input int r);
    int xi;
    int gi;
    int oi;
    bit started;
    xi      = 0;
    gi      = 0;
    oi      = 0;
    started = 1'b0;
    start_valid <= 1'b1;
    steps       <= rows[r].steps[`NTM_STEP_W-1:0];
    while (oi < N_OUT) begin
      @(posedge CLK); // Values below are the ones from before this edge
      if (started) begin
        assert (!start_ready) else begin
          $display("start_ready rose before the last output beat of row %0d", r);
          stop_with_failure();
        end
      end
      if (start_valid && start_ready) begin
        started = 1'b1;
        start_valid <= 1'b0;
      end
      if (x_valid && x_ready) begin
        xi++;
      end
      if (gate_valid && gate_ready) begin
        gi++;
      end
      if (out_valid && out_ready) begin
        assert (started) else begin
          $display("Output beat seen before the start transfer of row %0d", r);
          stop_with_failure();
        end
        check_beat(r, oi);
        oi++;
      end
      // Sources hold valid and payload until taken
      if (!x_valid || x_ready) begin
        if (xi < xq.size() && chance(rows[r].in_pct)) begin
          x_valid <= 1'b1;
          x_data  <= xq[xi];
        end else begin
          x_valid <= 1'b0;
        end
      end
      if (!gate_valid || gate_ready) begin
        if (gi < gq.size() && chance(rows[r].in_pct)) begin
          gate_valid <= 1'b1;
          gate       <= gq[gi];
        end else begin
          gate_valid <= 1'b0;
        end
      end
      out_ready <= chance(rows[r].out_pct);
    end
    assert (xi == xq.size() && gi == gq.size()) else begin
      $display("Row %0d ended with x or gate beats never taken", r);
      stop_with_failure();
    end
  endtask

  // Run limit
  always @(posedge CLK) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles with the run unfinished", cycles);
      stop_with_failure();
    end
  end

  ////////////////////////////////////////
  // Test table and sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(32'hccfe6501));
    rows[0] = '{steps: 1, in_pct: 100, out_pct: 100, directed: 1'b1};
    rows[1] = '{steps: 3, in_pct: 100, out_pct: 100, directed: 1'b0};
    rows[2] = '{steps: 8, in_pct: 100, out_pct: 50,  directed: 1'b0}; // Back-pressure
    rows[3] = '{steps: 3, in_pct: 60,  out_pct: 100, directed: 1'b0}; // Input bubbles
    rows[4] = '{steps: 8, in_pct: 60,  out_pct: 50,  directed: 1'b0};
    cycle_limit = cycle_budget();
    RST         = 1'b1;
    start_valid = 1'b0;
    steps       = '0;
    x_valid     = 1'b0;
    x_data      = '0;
    gate_valid  = 1'b0;
    gate        = '0;
    out_ready   = 1'b0;
    repeat (10) @(posedge CLK);
    RST <= 1'b0;
    @(posedge CLK);
    assert (start_ready && !x_ready && !gate_ready && !out_valid) else begin
      $display("Handshake outputs not idle after reset");
      stop_with_failure();
    end
    for (int r = 0; r < N_ROWS; r++) begin // Runs follow each other back to back
      build_row(r);
      run_row(r);
    end
    @(posedge CLK);
    assert (start_ready) else begin
      $display("start_ready stayed low after the final run");
      stop_with_failure();
    end
    $display("Regression passed");
    $finish;
  end

endmodule

// File: ntm_input_trainer.f
+incdir+.
ntm_trainer_pkg.sv
ntm_ctrl_pkg.sv
ntm_input_gate_delta.sv
ntm_gradient_accumulator.sv
ntm_trainer_controller.sv
ntm_input_trainer.sv
tb_ntm_input_trainer.sv

// File: Makefile
# Verilator build and run of the input gate trainer testbench

VERILATOR ?= verilator
TOP       ?= tb_ntm_input_trainer
SEED      ?= 1
FILELIST  ?= ntm_input_trainer.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# A $fatal in the testbench makes the binary exit non-zero
run: $(SIM_BIN)
	$(SIM_BIN) +verilator+seed+$(SEED)

clean:
	rm -rf $(BUILD_DIR)
